// ==== source/expipe_pkg.sv ====
// ------------------------------------------------------------
// FP pipeline shared sizes and types
// ------------------------------------------------------------

package expipe_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------

  // FP value width, single precision
  localparam int unsigned FLEN = 32;

  // Architectural FP registers
  localparam int unsigned REG_NUM = 32;
  localparam int unsigned REG_IDX_W = $clog2(REG_NUM);

  // Reorder buffer entries, power of two
  localparam int unsigned ROB_DEPTH = 8;
  localparam int unsigned ROB_IDX_W = $clog2(ROB_DEPTH);

  // Writer counter must reach ROB_DEPTH, hence one extra bit
  localparam int unsigned BUSY_W = ROB_IDX_W + 1;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------

  // Register index
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // ROB entry index, also used as the result tag
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  // FP data word
  typedef logic [FLEN-1:0] flen_t;

  // Number of in-flight writers of one register
  typedef logic [BUSY_W-1:0] busy_cnt_t;

  // Register status entry
  // Count of pending writers plus ROB tag of the youngest one
  typedef struct packed {
    busy_cnt_t count;
    rob_idx_t  rob_idx;
  } regstat_entry_t;

endpackage

// ==== source/fp_regstat.sv ====
// ------------------------------------------------------------
// FP register status table
// ------------------------------------------------------------

`timescale 1ns/1ps

module fp_regstat (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Issue side, already qualified with ROB room
  input  logic                 issue_valid_i,
  input  expipe_pkg::reg_idx_t issue_rd_idx_i,
  input  expipe_pkg::rob_idx_t issue_rob_idx_i,

  // Source operand lookups
  input  expipe_pkg::reg_idx_t issue_rs1_idx_i,
  input  expipe_pkg::reg_idx_t issue_rs2_idx_i,
  output logic                 issue_rs1_busy_o,
  output expipe_pkg::rob_idx_t issue_rs1_rob_idx_o,
  output logic                 issue_rs2_busy_o,
  output expipe_pkg::rob_idx_t issue_rs2_rob_idx_o,

  // Commit side
  input  logic                 comm_valid_i,
  input  expipe_pkg::reg_idx_t comm_rd_idx_i
);

  // One status entry per FP register
  expipe_pkg::regstat_entry_t regstat_q [expipe_pkg::REG_NUM];

  // ------------------------------------------------------------
  // Status update
  // ------------------------------------------------------------

  // Each register sees up to one increment (issue) and one decrement (commit)
  // Both on the same register cancel out, the tag still follows the issue
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < expipe_pkg::REG_NUM; i++) begin
        regstat_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < expipe_pkg::REG_NUM; i++) begin
        // Issue targets this register
        if (issue_valid_i && (issue_rd_idx_i == expipe_pkg::reg_idx_t'(i))) begin
          // New youngest writer
          regstat_q[i].rob_idx <= issue_rob_idx_i;
          // Count grows unless a commit on the same register offsets it
          if (!(comm_valid_i && (comm_rd_idx_i == expipe_pkg::reg_idx_t'(i)))) begin
            regstat_q[i].count <= regstat_q[i].count + expipe_pkg::busy_cnt_t'(1);
          end
        end else if (comm_valid_i && (comm_rd_idx_i == expipe_pkg::reg_idx_t'(i))) begin
          // Oldest writer left the ROB
          // Youngest tag kept, it is only read while count is nonzero
          regstat_q[i].count <= regstat_q[i].count - expipe_pkg::busy_cnt_t'(1);
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Read ports
  // ------------------------------------------------------------

  // rs1
  // Busy while any writer is still in flight
  assign issue_rs1_busy_o    = |regstat_q[issue_rs1_idx_i].count;
  // Tag of the result the operand waits on
  assign issue_rs1_rob_idx_o = regstat_q[issue_rs1_idx_i].rob_idx;

  // rs2
  assign issue_rs2_busy_o    = |regstat_q[issue_rs2_idx_i].count;
  assign issue_rs2_rob_idx_o = regstat_q[issue_rs2_idx_i].rob_idx;

endmodule

// ==== source/fp_rob.sv ====
// ------------------------------------------------------------
// FP reorder buffer
// ------------------------------------------------------------

`timescale 1ns/1ps

module fp_rob (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Allocation at issue
  input  logic                 alloc_valid_i,
  input  expipe_pkg::reg_idx_t alloc_rd_idx_i,
  output logic                 alloc_ready_o,
  output expipe_pkg::rob_idx_t alloc_idx_o,

  // Result writeback, any order
  input  logic                 wb_valid_i,
  input  expipe_pkg::rob_idx_t wb_idx_i,
  input  expipe_pkg::flen_t    wb_value_i,

  // Forwarding read ports
  input  expipe_pkg::rob_idx_t rd1_idx_i,
  input  expipe_pkg::rob_idx_t rd2_idx_i,
  output logic                 rd1_ready_o,
  output logic                 rd2_ready_o,
  output expipe_pkg::flen_t    rd1_value_o,
  output expipe_pkg::flen_t    rd2_value_o,

  // In-order retire
  output logic                 comm_valid_o,
  output expipe_pkg::reg_idx_t comm_rd_idx_o,
  output expipe_pkg::flen_t    comm_value_o,
  output expipe_pkg::rob_idx_t comm_idx_o
);

  // Entry state
  logic [expipe_pkg::ROB_DEPTH-1:0] valid_q;
  logic [expipe_pkg::ROB_DEPTH-1:0] ready_q;
  expipe_pkg::reg_idx_t             rd_q    [expipe_pkg::ROB_DEPTH];
  expipe_pkg::flen_t                value_q [expipe_pkg::ROB_DEPTH];

  // Pointers with wrap bit on top
  logic [expipe_pkg::ROB_IDX_W:0] head_q;
  logic [expipe_pkg::ROB_IDX_W:0] tail_q;

  expipe_pkg::rob_idx_t head_idx;
  expipe_pkg::rob_idx_t tail_idx;
  logic                 rob_full;
  logic                 alloc_fire;
  logic                 retire_fire;

  // ------------------------------------------------------------
  // Pointer decode
  // ------------------------------------------------------------

  assign head_idx = head_q[expipe_pkg::ROB_IDX_W-1:0];
  assign tail_idx = tail_q[expipe_pkg::ROB_IDX_W-1:0];

  // Full when indices match but wrap bits differ
  assign rob_full = (head_idx == tail_idx) &&
                    (head_q[expipe_pkg::ROB_IDX_W] != tail_q[expipe_pkg::ROB_IDX_W]);

  assign alloc_fire  = alloc_valid_i && !rob_full;
  // Head leaves once its result is in
  assign retire_fire = valid_q[head_idx] && ready_q[head_idx];

  // ------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      ready_q <= '0;
      head_q  <= '0;
      tail_q  <= '0;
    end else begin
      // Result arrived
      if (wb_valid_i) begin
        ready_q[wb_idx_i] <= 1'b1;
      end
      // New entry starts waiting for its result
      if (alloc_fire) begin
        valid_q[tail_idx] <= 1'b1;
        ready_q[tail_idx] <= 1'b0;
        tail_q            <= tail_q + (expipe_pkg::ROB_IDX_W + 1)'(1);
      end
      // Oldest entry retires
      if (retire_fire) begin
        valid_q[head_idx] <= 1'b0;
        head_q            <= head_q + (expipe_pkg::ROB_IDX_W + 1)'(1);
      end
    end
  end

  // ------------------------------------------------------------
  // Payload
  // ------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (alloc_fire) begin
      rd_q[tail_idx] <= alloc_rd_idx_i;
    end
    if (wb_valid_i) begin
      value_q[wb_idx_i] <= wb_value_i;
    end
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------

  // Room level and next tag
  assign alloc_ready_o = !rob_full;
  assign alloc_idx_o   = tail_idx;

  // Forwarding, ready only for a live entry with its result
  assign rd1_ready_o = valid_q[rd1_idx_i] && ready_q[rd1_idx_i];
  assign rd1_value_o = value_q[rd1_idx_i];
  assign rd2_ready_o = valid_q[rd2_idx_i] && ready_q[rd2_idx_i];
  assign rd2_value_o = value_q[rd2_idx_i];

  // Commit pulse and payload of the head
  assign comm_valid_o  = retire_fire;
  assign comm_rd_idx_o = rd_q[head_idx];
  assign comm_value_o  = value_q[head_idx];
  assign comm_idx_o    = head_idx;

endmodule

// ==== source/fp_regfile.sv ====
// ------------------------------------------------------------
// Architectural FP register file
// ------------------------------------------------------------

`timescale 1ns/1ps

module fp_regfile (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Commit write port
  input  logic                 we_i,
  input  expipe_pkg::reg_idx_t waddr_i,
  input  expipe_pkg::flen_t    wdata_i,

  // Operand read ports
  input  expipe_pkg::reg_idx_t raddr1_i,
  input  expipe_pkg::reg_idx_t raddr2_i,
  output expipe_pkg::flen_t    rdata1_o,
  output expipe_pkg::flen_t    rdata2_o
);

  // Register words
  expipe_pkg::flen_t regs_q [expipe_pkg::REG_NUM];

  // ------------------------------------------------------------
  // Write port
  // ------------------------------------------------------------

  // All words start at zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < expipe_pkg::REG_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // ------------------------------------------------------------
  // Read ports
  // ------------------------------------------------------------

  // Asynchronous, a write at the same edge shows up one cycle later
  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];

endmodule

// ==== source/fp_operand_resolve.sv ====
// ------------------------------------------------------------
// FP source operand resolver
// ------------------------------------------------------------

`timescale 1ns/1ps

module fp_operand_resolve (
  // Register status lookup
  input  logic                 busy_i,
  input  expipe_pkg::rob_idx_t tag_i,

  // ROB entry named by the tag
  input  logic                 rob_ready_i,
  input  expipe_pkg::flen_t    rob_value_i,

  // Architectural value
  input  expipe_pkg::flen_t    rf_value_i,

  // Resolved operand
  output logic                 op_ready_o,
  output expipe_pkg::flen_t    op_value_o,
  output expipe_pkg::rob_idx_t op_tag_o
);

  // ------------------------------------------------------------
  // Source selection
  // ------------------------------------------------------------

  // Three cases
  //   not busy            -> register file value, ready
  //   busy, entry ready   -> forwarded ROB value, ready
  //   busy, entry pending -> wait on tag
  always_comb begin
    if (!busy_i) begin
      // No writer in flight
      op_ready_o = 1'b1;
      op_value_o = rf_value_i;
    end else if (rob_ready_i) begin
      // Youngest writer has its result in the ROB
      op_ready_o = 1'b1;
      op_value_o = rob_value_i;
    end else begin
      // Still being computed
      // Value follows the ROB port and has no meaning here
      op_ready_o = 1'b0;
      op_value_o = rob_value_i;
    end
  end

  // ------------------------------------------------------------
  // Tag
  // ------------------------------------------------------------

  // Entry to wait for, only relevant when not ready
  assign op_tag_o = tag_i;

endmodule

// ==== source/fp_issue_core.sv ====
// ------------------------------------------------------------
// FP issue core top level
// ------------------------------------------------------------

`timescale 1ns/1ps

module fp_issue_core (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Issue
  input  logic                 issue_valid_i,
  input  expipe_pkg::reg_idx_t issue_rd_idx_i,
  input  expipe_pkg::reg_idx_t issue_rs1_idx_i,
  input  expipe_pkg::reg_idx_t issue_rs2_idx_i,
  output logic                 issue_ready_o,
  output expipe_pkg::rob_idx_t issue_rob_idx_o,

  // Operands of the presented instruction
  output logic                 op1_ready_o,
  output logic                 op2_ready_o,
  output expipe_pkg::flen_t    op1_value_o,
  output expipe_pkg::flen_t    op2_value_o,
  output expipe_pkg::rob_idx_t op1_tag_o,
  output expipe_pkg::rob_idx_t op2_tag_o,

  // Writeback
  input  logic                 wb_valid_i,
  input  expipe_pkg::rob_idx_t wb_rob_idx_i,
  input  expipe_pkg::flen_t    wb_value_i,

  // Commit
  output logic                 comm_valid_o,
  output expipe_pkg::reg_idx_t comm_rd_idx_o,
  output expipe_pkg::flen_t    comm_value_o,
  output expipe_pkg::rob_idx_t comm_rob_idx_o
);

  // Qualified issue strobe
  logic                 issue_fire;

  // Status lookups
  logic                 rs1_busy;
  logic                 rs2_busy;
  expipe_pkg::rob_idx_t rs1_tag;
  expipe_pkg::rob_idx_t rs2_tag;

  // ROB forwarding
  logic                 rob1_ready;
  logic                 rob2_ready;
  expipe_pkg::flen_t    rob1_value;
  expipe_pkg::flen_t    rob2_value;

  // Architectural values
  expipe_pkg::flen_t    rf1_value;
  expipe_pkg::flen_t    rf2_value;

  // Issue only counts with ROB room
  assign issue_fire = issue_valid_i & issue_ready_o;

  // ------------------------------------------------------------
  // Tracking blocks
  // ------------------------------------------------------------

  fp_regstat u_regstat (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .issue_valid_i       (issue_fire),
    .issue_rd_idx_i      (issue_rd_idx_i),
    .issue_rob_idx_i     (issue_rob_idx_o),
    .issue_rs1_idx_i     (issue_rs1_idx_i),
    .issue_rs2_idx_i     (issue_rs2_idx_i),
    .issue_rs1_busy_o    (rs1_busy),
    .issue_rs1_rob_idx_o (rs1_tag),
    .issue_rs2_busy_o    (rs2_busy),
    .issue_rs2_rob_idx_o (rs2_tag),
    .comm_valid_i        (comm_valid_o),
    .comm_rd_idx_i       (comm_rd_idx_o)
  );

  fp_rob u_rob (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .alloc_valid_i  (issue_fire),
    .alloc_rd_idx_i (issue_rd_idx_i),
    .alloc_ready_o  (issue_ready_o),
    .alloc_idx_o    (issue_rob_idx_o),
    .wb_valid_i     (wb_valid_i),
    .wb_idx_i       (wb_rob_idx_i),
    .wb_value_i     (wb_value_i),
    .rd1_idx_i      (rs1_tag),
    .rd2_idx_i      (rs2_tag),
    .rd1_ready_o    (rob1_ready),
    .rd2_ready_o    (rob2_ready),
    .rd1_value_o    (rob1_value),
    .rd2_value_o    (rob2_value),
    .comm_valid_o   (comm_valid_o),
    .comm_rd_idx_o  (comm_rd_idx_o),
    .comm_value_o   (comm_value_o),
    .comm_idx_o     (comm_rob_idx_o)
  );

  // Committed results land here
  fp_regfile u_regfile (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .we_i     (comm_valid_o),
    .waddr_i  (comm_rd_idx_o),
    .wdata_i  (comm_value_o),
    .raddr1_i (issue_rs1_idx_i),
    .raddr2_i (issue_rs2_idx_i),
    .rdata1_o (rf1_value),
    .rdata2_o (rf2_value)
  );

  // ------------------------------------------------------------
  // Operand resolution
  // ------------------------------------------------------------

  fp_operand_resolve u_resolve_op1 (
    .busy_i      (rs1_busy),
    .tag_i       (rs1_tag),
    .rob_ready_i (rob1_ready),
    .rob_value_i (rob1_value),
    .rf_value_i  (rf1_value),
    .op_ready_o  (op1_ready_o),
    .op_value_o  (op1_value_o),
    .op_tag_o    (op1_tag_o)
  );

  fp_operand_resolve u_resolve_op2 (
    .busy_i      (rs2_busy),
    .tag_i       (rs2_tag),
    .rob_ready_i (rob2_ready),
    .rob_value_i (rob2_value),
    .rf_value_i  (rf2_value),
    .op_ready_o  (op2_ready_o),
    .op_value_o  (op2_value_o),
    .op_tag_o    (op2_tag_o)
  );

endmodule

// ==== test/tb_clkgen.sv ====
// ------------------------------------------------------------
// Testbench clock and reset
// ------------------------------------------------------------

`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset held for 3 cycles, released just after an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

// ==== test/tb_fp_issue_core.sv ====
// ------------------------------------------------------------
// FP issue core testbench
// ------------------------------------------------------------

`timescale 1ns/1ps

module tb_fp_issue_core;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic                 issue_valid;
  expipe_pkg::reg_idx_t issue_rd;
  expipe_pkg::reg_idx_t issue_rs1;
  expipe_pkg::reg_idx_t issue_rs2;
  logic                 wb_valid;
  expipe_pkg::rob_idx_t wb_idx;
  expipe_pkg::flen_t    wb_value;

  // DUT outputs
  logic                 issue_ready_o;
  expipe_pkg::rob_idx_t issue_rob_idx_o;
  logic                 op1_ready_o;
  logic                 op2_ready_o;
  expipe_pkg::flen_t    op1_value_o;
  expipe_pkg::flen_t    op2_value_o;
  expipe_pkg::rob_idx_t op1_tag_o;
  expipe_pkg::rob_idx_t op2_tag_o;
  logic                 comm_valid_o;
  expipe_pkg::reg_idx_t comm_rd_idx_o;
  expipe_pkg::flen_t    comm_value_o;
  expipe_pkg::rob_idx_t comm_rob_idx_o;

  // Reference model state
  int                   m_cnt   [expipe_pkg::REG_NUM];
  expipe_pkg::rob_idx_t m_ytag  [expipe_pkg::REG_NUM];
  expipe_pkg::flen_t    m_arch  [expipe_pkg::REG_NUM];
  bit                   m_valid [expipe_pkg::ROB_DEPTH];
  bit                   m_rdy   [expipe_pkg::ROB_DEPTH];
  expipe_pkg::reg_idx_t m_rd    [expipe_pkg::ROB_DEPTH];
  expipe_pkg::flen_t    m_val   [expipe_pkg::ROB_DEPTH];
  int                   m_head;
  int                   m_tail;
  int                   m_count;

  int                   passes;
  int                   fails;
  logic [31:0]          rng_state = 32'd62;

  tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

  fp_issue_core dut0 (
    .clk_i (clk), .rst_n_i (rst_n),
    .issue_valid_i (issue_valid), .issue_rd_idx_i (issue_rd),
    .issue_rs1_idx_i (issue_rs1), .issue_rs2_idx_i (issue_rs2),
    .issue_ready_o (issue_ready_o), .issue_rob_idx_o (issue_rob_idx_o),
    .op1_ready_o (op1_ready_o), .op2_ready_o (op2_ready_o),
    .op1_value_o (op1_value_o), .op2_value_o (op2_value_o),
    .op1_tag_o (op1_tag_o), .op2_tag_o (op2_tag_o),
    .wb_valid_i (wb_valid), .wb_rob_idx_i (wb_idx), .wb_value_i (wb_value),
    .comm_valid_o (comm_valid_o), .comm_rd_idx_o (comm_rd_idx_o),
    .comm_value_o (comm_value_o), .comm_rob_idx_o (comm_rob_idx_o)
  );

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) passes++;
    else begin
      fails++;
      $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  task automatic model_reset();
    for (int i = 0; i < expipe_pkg::REG_NUM; i++) begin
      m_cnt[i]  = 0;
      m_ytag[i] = '0;
      m_arch[i] = '0;
    end
    for (int i = 0; i < expipe_pkg::ROB_DEPTH; i++) begin
      m_valid[i] = 1'b0;
      m_rdy[i]   = 1'b0;
    end
    m_head  = 0;
    m_tail  = 0;
    m_count = 0;
  endtask

  // One clock edge: retire, then writeback, then allocate
  task automatic model_step();
    bit                   fire;
    expipe_pkg::reg_idx_t crd;
    fire = issue_valid && (m_count < expipe_pkg::ROB_DEPTH);
    if (m_valid[m_head] && m_rdy[m_head]) begin
      crd         = m_rd[m_head];
      m_arch[crd] = m_val[m_head];
      m_cnt[crd]--;
      m_valid[m_head] = 1'b0;
      m_head          = (m_head + 1) % expipe_pkg::ROB_DEPTH;
      m_count--;
    end
    if (wb_valid) begin
      m_rdy[wb_idx] = 1'b1;
      m_val[wb_idx] = wb_value;
    end
    if (fire) begin
      m_valid[m_tail]  = 1'b1;
      m_rdy[m_tail]    = 1'b0;
      m_rd[m_tail]     = issue_rd;
      m_cnt[issue_rd]++;
      m_ytag[issue_rd] = expipe_pkg::rob_idx_t'(m_tail);
      m_tail           = (m_tail + 1) % expipe_pkg::ROB_DEPTH;
      m_count++;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) model_step();
  end

  // ------------------------------------------------------------
  // Output checks, mid-cycle when everything is settled
  // ------------------------------------------------------------

  task automatic check_operand(input string name, input expipe_pkg::reg_idx_t rs,
                               input logic rdy, input expipe_pkg::flen_t val,
                               input expipe_pkg::rob_idx_t tag);
    logic              exp_rdy;
    expipe_pkg::flen_t exp_val;
    exp_rdy = 1'b1;
    exp_val = m_arch[rs];
    // Youngest writer decides while any writer is in flight
    if (m_cnt[rs] != 0) begin
      exp_rdy = m_rdy[m_ytag[rs]];
      exp_val = m_val[m_ytag[rs]];
    end
    compare({name, "_ready_o"}, 32'(exp_rdy), 32'(rdy));
    if (exp_rdy) compare({name, "_value_o"}, exp_val, val);
    else compare({name, "_tag_o"}, 32'(m_ytag[rs]), 32'(tag));
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      compare("issue_ready_o", 32'(m_count < expipe_pkg::ROB_DEPTH), 32'(issue_ready_o));
      compare("issue_rob_idx_o", 32'(m_tail), 32'(issue_rob_idx_o));
      compare("comm_valid_o", 32'(m_valid[m_head] && m_rdy[m_head]), 32'(comm_valid_o));
      if (m_valid[m_head] && m_rdy[m_head]) begin
        compare("comm_rd_idx_o", 32'(m_rd[m_head]), 32'(comm_rd_idx_o));
        compare("comm_value_o", m_val[m_head], comm_value_o);
        compare("comm_rob_idx_o", 32'(m_head), 32'(comm_rob_idx_o));
      end
      check_operand("op1", issue_rs1, op1_ready_o, op1_value_o, op1_tag_o);
      check_operand("op2", issue_rs2, op2_ready_o, op2_value_o, op2_tag_o);
    end
  end

  // An issue turned away by a full ROB leaves the next tag where it was
  blocked_issue_keeps_tag: assert property (@(posedge clk) disable iff (!rst_n)
    (issue_valid && !issue_ready_o) |=> $stable(issue_rob_idx_o))
  else begin
    fails++;
    $display("At %0t an issue into a full ROB moved the next ROB tag", $time);
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------

  task automatic drive(input logic iv, input expipe_pkg::reg_idx_t rd,
                       input expipe_pkg::reg_idx_t rs1, input expipe_pkg::reg_idx_t rs2,
                       input logic wv, input expipe_pkg::rob_idx_t widx,
                       input expipe_pkg::flen_t wval);
    @(posedge clk);
    #1;
    issue_valid = iv;
    issue_rd    = rd;
    issue_rs1   = rs1;
    issue_rs2   = rs2;
    wb_valid    = wv;
    wb_idx      = widx;
    wb_value    = wval;
  endtask

  // First allocated entry still waiting for its result, from a start slot
  task automatic find_pending(input int start, output bit found,
                              output expipe_pkg::rob_idx_t idx);
    int e;
    found = 1'b0;
    idx   = '0;
    for (int k = 0; k < expipe_pkg::ROB_DEPTH; k++) begin
      e = (start + k) % expipe_pkg::ROB_DEPTH;
      if (!found && m_valid[e] && !m_rdy[e]) begin
        found = 1'b1;
        idx   = expipe_pkg::rob_idx_t'(e);
      end
    end
  endtask

  // Like drive, writeback goes to a random pending entry if any
  task automatic drive_auto(input logic iv, input expipe_pkg::reg_idx_t rd,
                            input expipe_pkg::reg_idx_t rs1,
                            input expipe_pkg::reg_idx_t rs2, input logic wb_en);
    bit                   found;
    expipe_pkg::rob_idx_t idx;
    @(posedge clk);
    #1;
    find_pending(int'(next_rand() % expipe_pkg::ROB_DEPTH), found, idx);
    issue_valid = iv;
    issue_rd    = rd;
    issue_rs1   = rs1;
    issue_rs2   = rs2;
    wb_valid    = wb_en && found;
    wb_idx      = idx;
    wb_value    = next_rand();
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("=== FAIL ===");
    $finish;
  endtask

  // Write back everything in flight and wait for the ROB to empty
  task automatic drain_rob();
    int n;
    n = 0;
    while (m_count != 0 && n < 100) begin
      drive_auto(1'b0, 5'd0, 5'd0, 5'd0, 1'b1);
      n++;
    end
    if (m_count != 0) abort_on_timeout("ROB did not drain within 100 cycles");
  endtask

  task automatic end_test(input string name, input int fails_before);
    @(negedge clk);
    #1;
    if (fails == fails_before) $display("test %s: ok", name);
    else $display("test %s: FAILED with %0d errors", name, fails - fails_before);
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    int          n;
    int          f0;
    int          base;
    logic [31:0] r;
    issue_valid = 1'b0;
    issue_rd    = '0;
    issue_rs1   = '0;
    issue_rs2   = '0;
    wb_valid    = 1'b0;
    wb_idx      = '0;
    wb_value    = '0;
    passes      = 0;
    fails       = 0;
    model_reset();
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) abort_on_timeout("reset never released");

    // Empty ROB, all registers zero
    f0 = fails;
    drive(1'b0, 5'd0, 5'd7, 5'd20, 1'b0, 3'd0, 32'h0);
    end_test("reset state", f0);

    // Reader of rd in the next cycle waits on the writer tag
    f0 = fails;
    drive(1'b1, 5'd3, 5'd1, 5'd2, 1'b0, 3'd0, 32'h0);
    drive(1'b0, 5'd0, 5'd3, 5'd9, 1'b0, 3'd0, 32'h0);
    drive(1'b0, 5'd0, 5'd9, 5'd3, 1'b0, 3'd0, 32'h0);
    drain_rob();
    end_test("dependency tag", f0);

    // Forward during the commit cycle, then register file
    f0   = fails;
    base = m_tail;
    drive(1'b1, 5'd5, 5'd0, 5'd0, 1'b0, 3'd0, 32'h0);
    drive(1'b0, 5'd0, 5'd5, 5'd5, 1'b1, 3'(base), 32'h3f80_0000);
    drive(1'b0, 5'd0, 5'd5, 5'd0, 1'b0, 3'd0, 32'h0);
    drive(1'b0, 5'd0, 5'd5, 5'd0, 1'b0, 3'd0, 32'h0);
    end_test("forwarding and commit", f0);

    // Results arrive youngest first, retire oldest first
    f0   = fails;
    base = m_tail;
    for (int i = 0; i < 4; i++) begin
      drive(1'b1, 5'(i + 1), 5'd0, 5'd0, 1'b0, 3'd0, 32'h0);
    end
    for (int i = 3; i >= 0; i--) begin
      drive(1'b0, 5'd0, 5'(i + 1), 5'd0, 1'b1, 3'(base + i), 32'h4000_0000 + 32'(i));
    end
    drain_rob();
    end_test("in-order retire", f0);

    // Fill the ROB, try one more, then free one slot
    // The turned away writer of r20 must not leave r20 busy
    f0   = fails;
    base = m_tail;
    for (int i = 0; i < expipe_pkg::ROB_DEPTH; i++) begin
      drive(1'b1, 5'(i + 8), 5'd0, 5'd0, 1'b0, 3'd0, 32'h0);
    end
    drive(1'b1, 5'd20, 5'd8, 5'd9, 1'b0, 3'd0, 32'h0);
    drive(1'b0, 5'd0, 5'd8, 5'd20, 1'b1, 3'(base), 32'h4100_0000);
    drive(1'b0, 5'd0, 5'd8, 5'd15, 1'b0, 3'd0, 32'h0);
    drive(1'b0, 5'd0, 5'd8, 5'd15, 1'b0, 3'd0, 32'h0);
    drain_rob();
    end_test("full ROB", f0);

    // Few destination registers so writers pile up
    f0 = fails;
    for (int i = 0; i < 300; i++) begin
      r = next_rand();
      drive_auto(r[0], 5'(r[3:2]), 5'(r[5:4]), 5'(r[7:6]), r[8] | r[9]);
    end
    drain_rob();
    for (int i = 0; i < expipe_pkg::REG_NUM; i++) begin
      drive(1'b0, 5'd0, 5'(i), 5'(expipe_pkg::REG_NUM - 1 - i), 1'b0, 3'd0, 32'h0);
    end
    end_test("random stream", f0);

    $display("Summary: %0d checks passed, %0d failed", passes, fails);
    if (fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== fp_issue_core.f ====
source/expipe_pkg.sv
source/fp_regstat.sv
source/fp_rob.sv
source/fp_regfile.sv
source/fp_operand_resolve.sv
source/fp_issue_core.sv
test/tb_clkgen.sv
test/tb_fp_issue_core.sv
